/* logic/rv_core_defs.svh */
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// Core sizing for the RV32I execution subsystem

// Data word width, shared by every datapath block
`define RV_XLEN 32

// Architectural register count
// x0 is included and always reads zero
`define RV_NREGS 32

// Scratch data memory depth in words
// Word index comes from address bits above the byte offset
`define RV_DMEM_WORDS 16

`endif

/* logic/rv_core_pkg.sv */
`include "rv_core_defs.svh"

package rv_core_pkg;

    // Major opcodes, bits 6:0 of the instruction
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,  // Register-register ALU
        OPC_OP_IMM = 7'b0010011,  // Register-immediate ALU
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,  // Only lw is supported
        OPC_STORE  = 7'b0100011   // Only sw is supported
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,   // Signed compare
        ALU_SLTU   // Unsigned compare
    } alu_op_e;

    // Write-back source, same code points as the register mux
    typedef enum logic [1:0] {
        WB_NONE = 2'b00,
        WB_MEM  = 2'b01,
        WB_IMM  = 2'b10,
        WB_ALU  = 2'b11
    } wb_sel_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;  // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;  // imm[4:0]
        logic [6:0] opcode;
    } s_fmt_t;

    // One instruction word, three field layouts
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
    } instr_u;

    // Decoded controls handed to the datapath
    typedef struct packed {
        alu_op_e    alu_op;
        logic       use_imm;   // ALU operand b from the immediate
        wb_sel_e    wb_sel;
        logic       reg_we;
        logic       mem_we;
        logic       illegal;
        logic [4:0] rd;
    } ctrl_t;

    // Returned with instr_ack
    typedef struct packed {
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] value;
        logic                wrote_reg;  // Register actually changed
        logic                illegal;
    } result_t;

endpackage

/* logic/rv_control.sv */
`include "rv_core_defs.svh"

module rv_control import rv_core_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                instr_req,  // Four-phase request from the agent
    input  instr_u              instr,
    output logic                instr_ack,
    output instr_u              cur_instr,  // Latched word, stable through EXEC and ACK
    output ctrl_t               ctrl,
    input  logic [`RV_XLEN-1:0] wb_value,   // Selected write-back data
    output result_t             result
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_EXEC,  // Exactly one cycle
        ST_ACK    // Held until req drops
    } state_e;

    state_e     state;
    ctrl_t      dec;    // Raw decode, enables not yet qualified by state
    logic [6:0] opcode;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       alt;    // funct7 of sub / sra

    assign opcode = cur_instr.r.opcode;
    assign f3     = cur_instr.r.funct3;
    assign f7     = cur_instr.r.funct7;  // Same bits as imm[11:5] in the I view
    assign alt    = (f7 == 7'b0100000);

    // funct3 to ALU op, shared by OP and OP_IMM
    function automatic alu_op_e f3_to_op(input logic [2:0] fn3, input logic alt_op);
        case (fn3)
            3'b000:  f3_to_op = alt_op ? ALU_SUB : ALU_ADD;
            3'b001:  f3_to_op = ALU_SLL;
            3'b010:  f3_to_op = ALU_SLT;
            3'b011:  f3_to_op = ALU_SLTU;
            3'b100:  f3_to_op = ALU_XOR;
            3'b101:  f3_to_op = alt_op ? ALU_SRA : ALU_SRL;
            3'b110:  f3_to_op = ALU_OR;
            default: f3_to_op = ALU_AND;
        endcase
    endfunction

    always_comb begin : decode
        dec    = '0;
        dec.rd = cur_instr.r.rd;
        case (opcode)
            OPC_OP: begin
                dec.alu_op  = f3_to_op(f3, alt);
                dec.wb_sel  = WB_ALU;
                dec.reg_we  = 1'b1;
                // Alternate funct7 only exists for sub and sra
                dec.illegal = !((f7 == 7'b0) || (alt && (f3 == 3'b000 || f3 == 3'b101)));
            end
            OPC_OP_IMM: begin
                dec.alu_op  = f3_to_op(f3, alt && (f3 == 3'b101));  // No subi
                dec.use_imm = 1'b1;
                dec.wb_sel  = WB_ALU;
                dec.reg_we  = 1'b1;
                if (f3 == 3'b001) begin
                    dec.illegal = (f7 != 7'b0);  // slli
                end else if (f3 == 3'b101) begin
                    dec.illegal = !((f7 == 7'b0) || alt);  // srli / srai
                end
            end
            OPC_LUI: begin
                dec.wb_sel = WB_IMM;
                dec.reg_we = 1'b1;
            end
            OPC_LOAD: begin
                dec.use_imm = 1'b1;  // Base plus offset
                dec.wb_sel  = WB_MEM;
                dec.reg_we  = 1'b1;
                dec.illegal = (f3 != 3'b010);  // Word only
            end
            OPC_STORE: begin
                dec.use_imm = 1'b1;
                dec.wb_sel  = WB_ALU;  // Reports the address sum, no register write
                dec.mem_we  = 1'b1;
                dec.illegal = (f3 != 3'b010);
            end
            default: dec.illegal = 1'b1;
        endcase
        if (dec.illegal) begin  // Illegal changes nothing
            dec.wb_sel = WB_NONE;
            dec.reg_we = 1'b0;
            dec.mem_we = 1'b0;
        end
    end

    // Writes only during the single EXEC cycle
    always_comb begin
        ctrl        = dec;
        ctrl.reg_we = dec.reg_we && (state == ST_EXEC);
        ctrl.mem_we = dec.mem_we && (state == ST_EXEC);
    end

    assign instr_ack = (state == ST_ACK);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= ST_IDLE;
            result <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (instr_req) begin
                        cur_instr <= instr;  // Agent holds it stable with req
                        state     <= ST_EXEC;
                    end
                end
                ST_EXEC: begin
                    result.rd        <= ctrl.rd;
                    result.value     <= wb_value;
                    result.wrote_reg <= ctrl.reg_we && (ctrl.rd != 5'd0);
                    result.illegal   <= ctrl.illegal;
                    state            <= ST_ACK;
                end
                default: begin
                    if (!instr_req) state <= ST_IDLE;  // Back-pressure holds here
                end
            endcase
        end
    end

endmodule

/* logic/rv_regfile.sv */
`include "rv_core_defs.svh"

module rv_regfile import rv_core_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [4:0]          rs1_addr,
    input  logic [4:0]          rs2_addr,
    input  logic [4:0]          rd_addr,
    input  logic                we,
    input  wb_sel_e             wb_sel,         // Write data source
    input  logic [`RV_XLEN-1:0] data_from_mem,
    input  logic [`RV_XLEN-1:0] data_from_imm,  // lui path
    input  logic [`RV_XLEN-1:0] data_from_alu,
    output logic [`RV_XLEN-1:0] wb_value,       // Also reported back to control
    output logic [`RV_XLEN-1:0] rs1_data,
    output logic [`RV_XLEN-1:0] rs2_data
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    // Three-way data select, none gives zero
    always_comb begin : select_wb
        case (wb_sel)
            WB_MEM:  wb_value = data_from_mem;
            WB_IMM:  wb_value = data_from_imm;
            WB_ALU:  wb_value = data_from_alu;
            default: wb_value = '0;
        endcase
    end

    // x0 forced to zero on read
    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd_addr != 5'd0)) begin  // Writes to x0 are dropped
            regs[rd_addr] <= wb_value;
        end
    end

endmodule

/* logic/rv_alu.sv */
`include "rv_core_defs.svh"

module rv_alu import rv_core_pkg::*; (
    input  alu_op_e             op,
    input  logic [`RV_XLEN-1:0] a,  // rs1
    input  logic [`RV_XLEN-1:0] b,  // rs2 or immediate
    output logic [`RV_XLEN-1:0] y
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b[4:0];  // Upper bits ignored, as in RV32I
    assign lt_s  = ($signed(a) < $signed(b));
    assign lt_u  = (a < b);

    always_comb begin
        case (op)
            ALU_ADD:  y = a + b;  // Also the lw / sw address
            ALU_SUB:  y = a - b;
            ALU_AND:  y = a & b;
            ALU_OR:   y = a | b;
            ALU_XOR:  y = a ^ b;
            ALU_SLL:  y = a << shamt;
            ALU_SRL:  y = a >> shamt;
            ALU_SRA:  y = $unsigned($signed(a) >>> shamt);  // Sign fill
            ALU_SLT:  y = {{(`RV_XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: y = {{(`RV_XLEN-1){1'b0}}, lt_u};
            default:  y = '0;
        endcase
    end

endmodule

/* logic/rv_imm_gen.sv */
`include "rv_core_defs.svh"

module rv_imm_gen import rv_core_pkg::*; (
    input  instr_u              instr,
    output logic [`RV_XLEN-1:0] imm
);

    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_u;

    // I-type, sign bit is instr[31]
    assign imm_i = {{(`RV_XLEN-12){instr.i.imm[11]}}, instr.i.imm};

    // S-type, split field rejoined
    assign imm_s = {{(`RV_XLEN-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};

    // U-type is bits 31:12 of the word with the low 12 cleared
    assign imm_u = {instr.i.imm, instr.i.rs1, instr.i.funct3, 12'b0};

    always_comb begin
        case (instr.r.opcode)
            OPC_OP_IMM, OPC_LOAD: imm = imm_i;
            OPC_STORE:            imm = imm_s;
            OPC_LUI:              imm = imm_u;
            default:              imm = '0;  // R-type and unknown
        endcase
    end

endmodule

/* logic/rv_dmem.sv */
`include "rv_core_defs.svh"

module rv_dmem (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [`RV_XLEN-1:0] addr,   // Byte address from the ALU
    input  logic                we,
    input  logic [`RV_XLEN-1:0] wdata,
    output logic [`RV_XLEN-1:0] rdata
);

    localparam int AW = $clog2(`RV_DMEM_WORDS);  // 4 for 16 words

    logic [`RV_XLEN-1:0] mem [`RV_DMEM_WORDS];
    logic [AW-1:0]       idx;

    // Byte offset dropped, upper bits wrap
    assign idx = addr[AW+1:2];

    assign rdata = mem[idx];  // Combinational read

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[idx] <= wdata;
        end
    end

endmodule

/* logic/rv_core_top.sv */
`include "rv_core_defs.svh"

module rv_core_top import rv_core_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    instr_req,
    input  instr_u  instr,
    output logic    instr_ack,
    output result_t result
);

    instr_u              cur_instr;
    ctrl_t               ctrl;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] alu_y;      // Result and memory address
    logic [`RV_XLEN-1:0] mem_rdata;
    logic [`RV_XLEN-1:0] wb_value;

    rv_control i_rv_control (
        .clk       (clk),
        .rst_n     (rst_n),
        .instr_req (instr_req),
        .instr     (instr),
        .instr_ack (instr_ack),
        .cur_instr (cur_instr),
        .ctrl      (ctrl),
        .wb_value  (wb_value),
        .result    (result)
    );

    rv_imm_gen i_rv_imm_gen (
        .instr (cur_instr),
        .imm   (imm)
    );

    rv_regfile i_rv_regfile (
        .clk           (clk),
        .rst_n         (rst_n),
        .rs1_addr      (cur_instr.r.rs1),
        .rs2_addr      (cur_instr.r.rs2),
        .rd_addr       (ctrl.rd),
        .we            (ctrl.reg_we),
        .wb_sel        (ctrl.wb_sel),
        .data_from_mem (mem_rdata),
        .data_from_imm (imm),
        .data_from_alu (alu_y),
        .wb_value      (wb_value),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data)
    );

    assign alu_b = ctrl.use_imm ? imm : rs2_data;  // Operand b select

    rv_alu i_rv_alu (
        .op (ctrl.alu_op),
        .a  (rs1_data),
        .b  (alu_b),
        .y  (alu_y)
    );

    rv_dmem i_rv_dmem (
        .clk   (clk),
        .rst_n (rst_n),
        .addr  (alu_y),
        .we    (ctrl.mem_we),
        .wdata (rs2_data),  // sw data
        .rdata (mem_rdata)
    );

endmodule

/* tb/tb_rv_core.sv */
`include "rv_core_defs.svh"

module tb_rv_core import rv_core_pkg::*; ();

    localparam int MAX_INSTR   = 300;                  // Upper bound over all tests
    localparam int CYCLE_LIMIT = MAX_INSTR * 8 + 100;  // At most 8 cycles per instruction
    localparam int HS_LIMIT    = 16;                   // Cycles allowed per handshake phase

    logic    clk;
    logic    rst_n;
    logic    instr_req;
    instr_u  instr;
    logic    instr_ack;
    result_t result;

    logic [`RV_XLEN-1:0] ref_regs [`RV_NREGS];  // Reference model state
    logic [`RV_XLEN-1:0] ref_mem  [`RV_DMEM_WORDS];
    logic [31:0]         rng_state   = 32'd1;
    int                  cycle_count = 0;
    int                  errors      = 0;
    int                  test_errors = 0;        // Errors of the running test
    int                  n_instr     = 0;
    int                  held_cycles = 0;        // Back-pressure cycles in total

    rv_core_top i_rv_core_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .instr_req (instr_req),
        .instr     (instr),
        .instr_ack (instr_ack),
        .result    (result)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return {rng_state[15:0], rng_state[31:16]};  // High half moved down since low bits are weak
    endfunction

    function automatic logic [31:0] pick(input logic [31:0] n);
        return lcg_next() % n;
    endfunction

    // RV32I semantics written from the ISA rules
    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << sh;
            3'd2:    return {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};  // Signs differ
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return (a >> sh) | ((alt && a[31]) ? ~(32'hffff_ffff >> sh) : 32'h0);
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic model_exec(input logic [31:0] w, output logic [31:0] value,
                              output logic wrote, output logic illegal);
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        f7      = w[31:25];
        f3      = w[14:12];
        rd      = w[11:7];
        a       = ref_regs[w[19:15]];  // Model x0 is never written
        b       = ref_regs[w[24:20]];
        value   = 32'h0;
        wrote   = 1'b0;
        illegal = 1'b0;
        case (w[6:0])
            7'b0110011: begin  // R-type
                illegal = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
                value   = ref_alu(f3, f7[5], a, b);
                wrote   = 1'b1;
            end
            7'b0010011: begin  // I-type with shamt in imm[4:0]
                illegal = (f3 == 3'd1 && f7 != 7'h00) ||
                          (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
                value   = ref_alu(f3, f3 == 3'd5 && f7[5], a, {{20{w[31]}}, w[31:20]});
                wrote   = 1'b1;
            end
            7'b0110111: begin
                value = {w[31:12], 12'h0};
                wrote = 1'b1;
            end
            7'b0000011: begin  // lw
                illegal = (f3 != 3'd2);
                addr    = a + {{20{w[31]}}, w[31:20]};
                value   = ref_mem[addr[5:2]];
                wrote   = 1'b1;
            end
            7'b0100011: begin  // sw reports the address
                illegal = (f3 != 3'd2);
                addr    = a + {{20{w[31]}}, w[31:25], w[11:7]};
                value   = addr;
                if (!illegal) ref_mem[addr[5:2]] = b;
            end
            default: illegal = 1'b1;
        endcase
        if (illegal) begin
            value = 32'h0;
            wrote = 1'b0;
        end
        wrote = wrote && (rd != 5'd0);
        if (wrote) ref_regs[rd] = value;
    endtask

    // One four-phase transfer checked against the model
    task automatic run_instr(input string name, input logic [31:0] w);
        logic [31:0] exp_value;
        logic        exp_wrote;
        logic        exp_illegal;
        result_t     held;
        int          waited;
        int          hold;
        model_exec(w, exp_value, exp_wrote, exp_illegal);
        n_instr++;
        instr     = w;
        instr_req = 1'b1;
        waited    = 0;
        @(negedge clk);
        while (!instr_ack && waited < HS_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!instr_ack) begin
            $display("%s: no instr_ack for instruction %h", name, w);
            test_errors++;
        end else begin
            if (result.rd !== w[11:7]) begin
                $display("Fail %s (%h) rd: expected %0d, actual %0d", name, w, w[11:7], result.rd);
                test_errors++;
            end
            if (result.value !== exp_value) begin
                $display("Fail %s (%h) value: expected %h, actual %h",
                         name, w, exp_value, result.value);
                test_errors++;
            end
            if (result.wrote_reg !== exp_wrote) begin
                $display("Fail %s (%h) wrote_reg: expected %0b, actual %0b",
                         name, w, exp_wrote, result.wrote_reg);
                test_errors++;
            end
            if (result.illegal !== exp_illegal) begin
                $display("Fail %s (%h) illegal: expected %0b, actual %0b",
                         name, w, exp_illegal, result.illegal);
                test_errors++;
            end
            held = result;
            hold = int'(pick(6));  // Req stays high for 0 to 5 more cycles
            held_cycles += hold;
            repeat (hold) begin
                @(negedge clk);
                if (!instr_ack || result !== held) begin
                    $display("%s: instr_ack or result changed while instr_req was held", name);
                    test_errors++;
                end
            end
        end
        instr_req = 1'b0;
        waited    = 0;
        @(negedge clk);
        while (instr_ack && waited < HS_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (instr_ack) begin
            $display("%s: instr_ack did not drop after instr_req fell", name);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        $display("%s: done, %0d errors", name, test_errors);
        errors      += test_errors;
        test_errors  = 0;
    endtask

    // Random legal R-type or I-type ALU op
    function automatic logic [31:0] rand_alu(input logic [4:0] rd);
        logic [31:0] r;
        logic [2:0]  f3;
        logic [6:0]  f7;
        r  = lcg_next();
        f3 = r[2:0];
        f7 = (r[3] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;  // sub or sra
        if (r[4])
            return {f7, r[9:5], r[14:10], f3, rd, 7'b0110011};
        if (f3 == 3'd1 || f3 == 3'd5)  // Shift immediate
            return {f7, r[19:15], r[14:10], f3, rd, 7'b0010011};
        return {r[31:20], r[14:10], f3, rd, 7'b0010011};
    endfunction

    initial begin
        logic [31:0] r;
        logic [31:0] sw_word;
        logic [6:0]  opc;
        logic [2:0]  f3;
        rst_n     = 1'b0;
        instr_req = 1'b0;
        instr     = '0;
        for (int k = 0; k < `RV_NREGS; k++)
            ref_regs[k] = '0;
        for (int k = 0; k < `RV_DMEM_WORDS; k++)
            ref_mem[k] = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        if (instr_ack !== 1'b0) begin
            $display("reset: instr_ack is high after reset");
            test_errors++;
        end
        if (result !== '0) begin
            $display("Fail reset result: expected %h, actual %h", 39'h0, result);
            test_errors++;
        end
        for (int k = 1; k < `RV_NREGS; k++)
            run_instr("reset", {7'h00, 5'd0, 5'(k), 3'd0, 5'd0, 7'b0110011});  // add x0, xk, x0
        finish_test("reset");

        for (int k = 0; k < 6; k++) begin  // Seeds registers with large values
            r = lcg_next();
            run_instr("lui", {r[31:12], 5'(pick(31) + 1), 7'b0110111});
        end
        finish_test("lui");

        for (int k = 0; k < 200; k++)
            run_instr("alu", rand_alu(5'(pick(32))));
        finish_test("alu");

        for (int k = 0; k < 3; k++) begin
            r = lcg_next();
            run_instr("x0", (k == 0) ? {r[31:12], 5'd0, 7'b0110111} : rand_alu(5'd0));
            run_instr("x0", {7'h00, 5'd0, 5'd0, 3'd0, 5'(pick(31) + 1), 7'b0110011});  // Reads x0
        end
        finish_test("x0");

        for (int k = 0; k < 10; k++) begin
            r       = lcg_next();
            sw_word = {r[31:15], 3'b010, r[11:7], 7'b0100011};
            run_instr("mem", sw_word);
            r = lcg_next();
            if (r[0])  // Same base and offset as the store
                run_instr("mem", {sw_word[31:25], sw_word[11:7], sw_word[19:15], 3'b010,
                                  r[11:7], 7'b0000011});
            else
                run_instr("mem", {r[31:15], 3'b010, r[11:7], 7'b0000011});
        end
        finish_test("mem");

        for (int k = 0; k < 8; k++) begin
            r   = lcg_next();
            opc = r[6:0];
            if (opc inside {7'b0110011, 7'b0010011, 7'b0110111, 7'b0000011, 7'b0100011})
                opc = 7'b1101111;
            f3 = (r[14:12] == 3'd0 || r[14:12] == 3'd5) ? 3'd4 : r[14:12];
            case (k % 3)
                0: run_instr("illegal", {r[31:7], opc});
                1: run_instr("illegal", {7'h20, r[24:15], f3, r[11:7], 7'b0110011});
                default: run_instr("illegal", {r[31:15], (f3 == 3'd2) ? 3'd3 : f3, r[11:7],
                                               r[0] ? 7'b0000011 : 7'b0100011});
            endcase
            // Its rd and its store address read back into x0
            run_instr("illegal", {7'h00, 5'd0, r[11:7], 3'd0, 5'd0, 7'b0110011});
            run_instr("illegal", {r[31:25], r[11:7], r[19:15], 3'b010, 5'd0, 7'b0000011});
        end
        finish_test("illegal");

        $display("Checked %0d instructions, %0d held cycles, %0d errors",
                 n_instr, held_cycles, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* sources.f */
+incdir+logic
logic/rv_core_pkg.sv
logic/rv_control.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_imm_gen.sv
logic/rv_dmem.sv
logic/rv_core_top.sv
tb/tb_rv_core.sv

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f sources.f --top-module tb_rv_core -o tb_rv_core \
    || { echo "Verilator build failed"; exit 1; }

out=$(./obj_dir/tb_rv_core)
echo "$out"
echo "$out" | grep -q "^RESULT: PASS$" && echo "Simulation passed" && exit 0 \
    || { echo "Simulation failed"; exit 1; }
